// ==== bchWbDecoder.f ====
+incdir+rtl
rtl/bchPkg.sv
rtl/bchSyndrome.sv
rtl/bchErrorLocator.sv
rtl/bchChienSearch.sv
rtl/bchWbDecoder.sv
bench/bchClockGen.sv
bench/bchWbDecoder_properties.sv
bench/bchWbDecoder_tb.sv

// ==== bench/bchClockGen.sv ====
`timescale 1ns/1ps

module bchClockGen (
	output logic clk,
	output logic rstN
);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// reset held low for eight rising edges
	initial begin
		rstN = 1'b0;
		repeat (8) @(posedge clk);
		#1;
		rstN = 1'b1;
	end

endmodule

// ==== bench/bchWbDecoder_properties.sv ====
`timescale 1ns/1ps
`include "bch_params.svh"

module bchWbDecoder_properties (
	input logic clk,
	input logic rstN,
	input logic cyc,
	input logic stb,
	input logic ack,
	input bchPkg::decodeStatusT status
);

	// number of property failures seen so far
	int failCount = 0;

	// ack is a single cycle pulse
	ackPulse: assert property (@(posedge clk) disable iff (!rstN) ack |=> !ack)
		else begin
			$error("ack held for more than one cycle");
			failCount++;
		end

	ackAfterStrobe: assert property (@(posedge clk) disable iff (!rstN)
		ack |-> $past(cyc && stb))
		else begin
			$error("ack raised without a preceding cyc and stb");
			failCount++;
		end

	// decode length is fixed
	busyLength: assert property (@(posedge clk) disable iff (!rstN)
		$rose(status.busy) |-> ##`BCH_DECODE_CYCLES $fell(status.busy))
		else begin
			$error("busy did not fall after the fixed decode length");
			failCount++;
		end

	failedIdle: assert property (@(posedge clk) disable iff (!rstN)
		!(status.busy && status.failed))
		else begin
			$error("failed flag high during a decode");
			failCount++;
		end

endmodule

// ==== bench/bchWbDecoder_tb.sv ====
`timescale 1ns/1ps
`include "bch_params.svh"

module bchWbDecoder_tb;

	typedef struct packed {
		bchPkg::codewordT received;
		bchPkg::codewordT expected;
		logic [1:0] errCount;
		logic failed;
	} vectorT;

	logic clk;
	logic rstN;
	logic cyc;
	logic stb;
	logic we;
	logic [1:0] adr;
	logic [31:0] datW;
	logic [31:0] datR;
	logic ack;
	vectorT vectors [$];
	int cycles = 0;
	int limit = 0;

	bchClockGen clkGen_i (
		.clk(clk),
		.rstN(rstN)
	);

	bchWbDecoder dut_i (
		.clk(clk),
		.rstN(rstN),
		.cyc(cyc),
		.stb(stb),
		.we(we),
		.adr(adr),
		.datW(datW),
		.datR(datR),
		.ack(ack)
	);

	bind bchWbDecoder bchWbDecoder_properties props_i (
		.clk(clk),
		.rstN(rstN),
		.cyc(cyc),
		.stb(stb),
		.ack(ack),
		.status(status)
	);

	task automatic failRun(input string reason);
		$display("%s", reason);
		$display("Some tests failed");
		$fatal(1);
	endtask

	task automatic checkValue(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		assert (got === exp) else
			failRun($sformatf("ERR %s: got 0x%0h, expected 0x%0h", name, got, exp));
	endtask

	// one classic cycle, then a random idle gap
	task automatic busAccess(input logic write, input logic [1:0] addr,
			input logic [31:0] data, output logic [31:0] rdata);
		int gap;
		cyc = 1'b1;
		stb = 1'b1;
		we = write;
		adr = addr;
		datW = data;
		@(negedge clk);
		while (!ack)
			@(negedge clk);
		rdata = datR;
		@(posedge clk);
		#1;
		cyc = 1'b0;
		stb = 1'b0;
		we = 1'b0;
		gap = $urandom_range(3);
		repeat (gap) begin
			@(posedge clk);
			#1;
		end
	endtask

	task automatic loadVectors();
		int fd;
		int n;
		int cnt;
		int flag;
		string line;
		logic [31:0] rx;
		logic [31:0] good;
		vectorT v;
		fd = $fopen("bench/bch_stimulus.txt", "r");
		if (fd == 0) begin
			failRun("could not open bench/bch_stimulus.txt");
		end else begin
			while (!$feof(fd)) begin
				n = $fgets(line, fd);
				if (n > 0 && line.substr(0, 0) != "#") begin
					n = $sscanf(line, "%h %h %d %d", rx, good, cnt, flag);
					if (n == 4) begin
						v.received = rx[`BCH_N-1:0];
						v.expected = good[`BCH_N-1:0];
						v.errCount = cnt[1:0];
						v.failed = flag[0];
						vectors.push_back(v);
					end
				end
			end
			$fclose(fd);
		end
	endtask

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (limit > 0 && cycles >= limit)
			failRun("timeout: decoder never finished");
		else if (dut_i.props_i.failCount != 0)
			failRun("a bus or status property failed");
	end

	initial begin
		vectorT v;
		logic [31:0] rd;
		bchPkg::decodeStatusT st;
		cyc = 1'b0;
		stb = 1'b0;
		we = 1'b0;
		adr = '0;
		datW = '0;
		void'($urandom(32'ha054));
		loadVectors();
		limit = vectors.size() * (`BCH_DECODE_CYCLES + 40);
		@(posedge rstN);
		@(posedge clk);
		#1;
		busAccess(1'b0, 2'd0, '0, rd);
		checkValue("status", rd, '0);
		busAccess(1'b0, 2'd1, '0, rd);
		checkValue("corrected", rd, '0);
		for (int a = 2; a < 4; a++) begin
			busAccess(1'b0, 2'(a), '0, rd);
			checkValue("datR", rd, '0);
		end
		foreach (vectors[i]) begin
			v = vectors[i];
			busAccess(1'b1, 2'd0, {17'd0, v.received}, rd);
			// second word lands while busy and must be dropped
			busAccess(1'b1, 2'd0, {17'd0, ~v.received}, rd);
			busAccess(1'b0, 2'd0, '0, rd);
			st = rd[7:0];
			checkValue("busy", st.busy, 1'b1);
			while (st.busy) begin
				busAccess(1'b0, 2'd0, '0, rd);
				st = rd[7:0];
			end
			checkValue("errCount", st.errCount, v.errCount);
			checkValue("failed", st.failed, v.failed);
			busAccess(1'b0, 2'd1, '0, rd);
			checkValue("corrected", rd, {17'd0, v.expected});
		end
		if (dut_i.props_i.failCount != 0) begin
			failRun("a bus or status property failed");
		end else begin
			$display("All tests passed");
			$finish;
		end
	end

endmodule

// ==== bench/bch_stimulus.txt ====
# received corrected errCount failed
# 15-bit words in hex, bit 14 is the first bit on the line
0000 0000 0 0
0537 0537 0 0
7fff 7fff 0 0
5647 5647 0 0
4537 0537 1 0
0f58 0f59 1 0
0aef 0a6e 2 0
3ffe 7fff 2 0
7332 5370 3 0
4088 0000 3 0
5640 5647 3 0
0017 0537 3 0
000f 000f 3 1
7ff0 7ff0 3 1
5380 5380 3 1
0a71 0a71 3 1

// ==== rtl/bchChienSearch.sv ====
`timescale 1ns/1ps
`include "bch_params.svh"

module bchChienSearch (
	input  logic clk,
	input  logic rstN,
	input  logic start,
	input  bchPkg::locatorT loc,
	input  bchPkg::codewordT received,
	output bchPkg::codewordT corrected,
	output logic [1:0] rootCount,
	output logic rootsMismatch,
	output logic searchDone
);

	bchPkg::gfElemT terms [0:3];
	bchPkg::gfElemT termNext [1:3];
	bchPkg::gfElemT evalSum;
	bchPkg::codewordT work;
	bchPkg::codewordT workNext;
	bchPkg::codewordT rcv;
	logic [1:0] degree;
	logic [1:0] cnt;
	logic [1:0] cntNext;
	logic [3:0] pos;
	logic active;
	logic isRoot;

	// term j steps by alpha^j, so the sum is the locator at alpha^k
	always_comb begin
		termNext[1] = bchPkg::gfMul(terms[1], 4'h2);
		termNext[2] = bchPkg::gfMul(terms[2], 4'h4);
		termNext[3] = bchPkg::gfMul(terms[3], 4'h8);
		evalSum = terms[0] ^ termNext[1] ^ termNext[2] ^ termNext[3];
	end

	// a root at alpha^k points at position 15 - k
	assign isRoot = (evalSum == '0);
	assign cntNext = cnt + {1'b0, isRoot};
	assign workNext = work ^ (bchPkg::codewordT'(isRoot) << pos);

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			active <= 1'b0;
			pos <= '0;
			searchDone <= 1'b0;
		end else begin
			searchDone <= 1'b0;
			if (start) begin
				active <= 1'b1;
				pos <= 4'(`BCH_N - 1);
			end else if (active) begin
				pos <= pos - 4'd1;
				if (pos == 4'd0) begin
					active <= 1'b0;
					searchDone <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			terms[0] <= loc.lambda0;
			terms[1] <= loc.lambda1;
			terms[2] <= loc.lambda2;
			terms[3] <= loc.lambda3;
			degree <= loc.degree;
			work <= received;
			rcv <= received;
			cnt <= '0;
		end else if (active) begin
			terms[1] <= termNext[1];
			terms[2] <= termNext[2];
			terms[3] <= termNext[3];
			cnt <= cntNext;
			work <= workNext;
			if (pos == 4'd0) begin
				rootCount <= cntNext;
				rootsMismatch <= (cntNext != degree);
				// undecodable word goes out as received
				corrected <= (cntNext != degree) ? rcv : workNext;
			end
		end
	end

endmodule

// ==== rtl/bchErrorLocator.sv ====
`timescale 1ns/1ps
`include "bch_params.svh"

module bchErrorLocator (
	input  logic clk,
	input  logic rstN,
	input  logic start,
	input  bchPkg::syndromeT syn,
	output bchPkg::locatorT loc,
	output logic locDone
);

	bchPkg::gfElemT synArr [1:5];
	bchPkg::gfElemT lam [0:`BCH_T];
	bchPkg::gfElemT corr [0:`BCH_T];
	bchPkg::gfElemT corrNext [0:`BCH_T];
	bchPkg::gfElemT disc;
	bchPkg::gfElemT discComb;
	bchPkg::gfElemT sq;
	bchPkg::gfElemT inv;
	bchPkg::gfElemT mulA;
	bchPkg::gfElemT mulB;
	bchPkg::gfElemT mulOut;
	logic [2:0] lenL;
	logic [2:0] lenNext;
	logic [2:0] r;
	logic [1:0] iter;
	logic [3:0] ph;
	logic [1:0] term;
	logic upd;
	logic running;

	// odd step index 1, 3, 5
	assign r = {iter, 1'b1};
	assign term = ph[1:0];
	assign lenNext = upd ? (r - lenL) : lenL;

	always_comb begin
		discComb = '0;
		for (int i = 0; i <= `BCH_T; i++) begin
			if (i < r)
				discComb ^= bchPkg::gfMul(lam[i], synArr[r - i]);
		end
	end

	// one shared multiplier, operands picked by phase
	always_comb begin
		mulA = inv;
		mulB = bchPkg::gfSquare(sq);
		if (ph >= 4'd8) begin
			mulA = corr[term];
			mulB = disc;
		end else if (ph >= 4'd4) begin
			mulA = (term >= 2'd2) ? lam[term - 2'd2] : '0;
			mulB = inv;
		end
	end

	assign mulOut = bchPkg::gfMul(mulA, mulB);

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			running <= 1'b0;
			iter <= '0;
			ph <= '0;
			locDone <= 1'b0;
		end else begin
			locDone <= 1'b0;
			if (start) begin
				running <= 1'b1;
				iter <= '0;
				ph <= '0;
			end else if (running) begin
				if (ph == 4'd11) begin
					ph <= '0;
					iter <= iter + 2'd1;
					if (iter == 2'd2) begin
						running <= 1'b0;
						locDone <= 1'b1;
					end
				end else begin
					ph <= ph + 4'd1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			// even syndromes of a binary code are squares
			synArr[1] <= syn.s1;
			synArr[2] <= bchPkg::gfSquare(syn.s1);
			synArr[3] <= syn.s3;
			synArr[4] <= bchPkg::gfSquare(bchPkg::gfSquare(syn.s1));
			synArr[5] <= syn.s5;
			lam[0] <= 4'h1;
			lam[1] <= '0;
			lam[2] <= '0;
			lam[3] <= '0;
			// correction term starts as x
			corr[0] <= '0;
			corr[1] <= 4'h1;
			corr[2] <= '0;
			corr[3] <= '0;
			lenL <= '0;
		end else if (running) begin
			if (ph == 4'd0) begin
				disc <= discComb;
				sq <= discComb;
				upd <= (discComb != '0) && (lenL <= {1'b0, iter});
			end else if (ph == 4'd1) begin
				sq <= bchPkg::gfSquare(sq);
				inv <= bchPkg::gfSquare(sq);
			end else if (ph < 4'd4) begin
				// d^6 then d^14, which is 1/d
				sq <= bchPkg::gfSquare(sq);
				inv <= mulOut;
			end else if (ph < 4'd8) begin
				corrNext[term] <= mulOut;
			end else begin
				lam[term] <= lam[term] ^ mulOut;
				if (ph == 4'd11) begin
					lenL <= lenNext;
					if (upd) begin
						corr <= corrNext;
					end else begin
						corr[3] <= corr[1];
						corr[2] <= corr[0];
						corr[1] <= '0;
						corr[0] <= '0;
					end
					if (iter == 2'd2) begin
						if (lenNext > 3'd3) begin
							// too many errors, hand on a rootless locator
							loc.lambda0 <= 4'h1;
							loc.lambda1 <= '0;
							loc.lambda2 <= '0;
							loc.lambda3 <= '0;
							loc.degree <= 2'd3;
						end else begin
							loc.lambda0 <= lam[0];
							loc.lambda1 <= lam[1];
							loc.lambda2 <= lam[2];
							loc.lambda3 <= lam[3] ^ mulOut;
							loc.degree <= lenNext[1:0];
						end
					end
				end
			end
		end
	end

endmodule

// ==== rtl/bchPkg.sv ====
package bchPkg;

`include "bch_params.svh"

	typedef logic [`BCH_M-1:0] gfElemT;

	// bit 14 is sent first and carries x^14
	typedef logic [`BCH_N-1:0] codewordT;

	typedef struct packed {
		gfElemT s5;
		gfElemT s3;
		gfElemT s1;
	} syndromeT;

	typedef struct packed {
		gfElemT lambda3;
		gfElemT lambda2;
		gfElemT lambda1;
		gfElemT lambda0;
		logic [1:0] degree;
	} locatorT;

	typedef struct packed {
		logic [3:0] reserved;
		logic [1:0] errCount;
		logic failed;
		logic busy;
	} decodeStatusT;

	// shift and add, reducing by the field polynomial each step
	function automatic gfElemT gfMul(input gfElemT a, input gfElemT b);
		gfElemT acc;
		gfElemT sh;
		acc = '0;
		sh = a;
		for (int i = 0; i < `BCH_M; i++) begin
			if (b[i])
				acc ^= sh;
			sh = {sh[`BCH_M-2:0], 1'b0} ^ (sh[`BCH_M-1] ? `BCH_POLY : '0);
		end
		return acc;
	endfunction

	function automatic gfElemT gfSquare(input gfElemT a);
		return gfMul(a, a);
	endfunction

endpackage

// ==== rtl/bchSyndrome.sv ====
`timescale 1ns/1ps
`include "bch_params.svh"

module bchSyndrome (
	input  logic clk,
	input  logic rstN,
	input  logic bitIn,
	input  logic bitValid,
	input  logic first,
	output bchPkg::syndromeT syn,
	output logic synDone
);

	bchPkg::syndromeT accBase;
	bchPkg::gfElemT bitElem;
	logic [3:0] pos;
	logic [3:0] curPos;

	always_comb begin
		// a new word restarts the accumulators from zero
		accBase = first ? '0 : syn;
		bitElem = {{(`BCH_M - 1){1'b0}}, bitIn};
		curPos = first ? 4'(`BCH_N - 1) : pos;
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			pos <= '0;
			synDone <= 1'b0;
		end else begin
			// done follows bit 0
			synDone <= bitValid && (curPos == 4'd0);
			if (bitValid)
				pos <= curPos - 4'd1;
		end
	end

	// horner steps with alpha, alpha^3 and alpha^5
	always_ff @(posedge clk) begin
		if (bitValid) begin
			syn.s1 <= bchPkg::gfMul(accBase.s1, 4'h2) ^ bitElem;
			syn.s3 <= bchPkg::gfMul(accBase.s3, 4'h8) ^ bitElem;
			syn.s5 <= bchPkg::gfMul(accBase.s5, 4'h6) ^ bitElem;
		end
	end

endmodule

// ==== rtl/bchWbDecoder.sv ====
`timescale 1ns/1ps
`include "bch_params.svh"

module bchWbDecoder (
	input  logic clk,
	input  logic rstN,
	input  logic cyc,
	input  logic stb,
	input  logic we,
	input  logic [1:0] adr,
	input  logic [31:0] datW,
	output logic [31:0] datR,
	output logic ack
);

	bchPkg::codewordT rxWord;
	bchPkg::codewordT corrWord;
	bchPkg::codewordT corrected;
	bchPkg::decodeStatusT status;
	bchPkg::syndromeT syn;
	bchPkg::locatorT loc;
	logic [1:0] rootCount;
	logic rootsMismatch;
	logic synDone;
	logic locDone;
	logic searchDone;
	logic [3:0] shiftPos;
	logic shiftOn;
	logic bitValid;
	logic bitIn;
	logic first;
	logic startWrite;

	// writes land in the ack cycle, ignored while a decode runs
	assign startWrite = cyc && stb && ack && we && (adr == 2'd0) && !status.busy;

	assign bitValid = shiftOn;
	assign bitIn = rxWord[shiftPos];
	assign first = shiftOn && (shiftPos == 4'(`BCH_N - 1));

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN)
			ack <= 1'b0;
		else
			ack <= cyc && stb && !ack;
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			rxWord <= '0;
			corrWord <= '0;
			status <= '0;
			shiftOn <= 1'b0;
			shiftPos <= '0;
		end else begin
			if (startWrite) begin
				rxWord <= datW[`BCH_N-1:0];
				status.busy <= 1'b1;
				status.failed <= 1'b0;
				status.errCount <= '0;
				shiftOn <= 1'b1;
				shiftPos <= 4'(`BCH_N - 1);
			end else if (shiftOn) begin
				shiftPos <= shiftPos - 4'd1;
				if (shiftPos == 4'd0)
					shiftOn <= 1'b0;
			end
			if (searchDone) begin
				corrWord <= corrected;
				status.busy <= 1'b0;
				status.failed <= rootsMismatch;
				status.errCount <= rootsMismatch ? loc.degree : rootCount;
			end
		end
	end

	always_comb begin
		datR = '0;
		case (adr)
			2'd0: datR[$bits(bchPkg::decodeStatusT)-1:0] = status;
			2'd1: datR[`BCH_N-1:0] = corrWord;
			default: datR = '0;
		endcase
	end

	bchSyndrome syndrome_i (
		.clk(clk),
		.rstN(rstN),
		.bitIn(bitIn),
		.bitValid(bitValid),
		.first(first),
		.syn(syn),
		.synDone(synDone)
	);

	bchErrorLocator locator_i (
		.clk(clk),
		.rstN(rstN),
		.start(synDone),
		.syn(syn),
		.loc(loc),
		.locDone(locDone)
	);

	bchChienSearch search_i (
		.clk(clk),
		.rstN(rstN),
		.start(locDone),
		.loc(loc),
		.received(rxWord),
		.corrected(corrected),
		.rootCount(rootCount),
		.rootsMismatch(rootsMismatch),
		.searchDone(searchDone)
	);

endmodule

// ==== rtl/bch_params.svh ====
`ifndef BCH_PARAMS_SVH
`define BCH_PARAMS_SVH

// field is GF(2^4)
`define BCH_M 4
`define BCH_N 15
`define BCH_T 3

// x^4 + x + 1 with the x^4 term left out
`define BCH_POLY 4'h3

// 15 syndrome + 36 locator + 16 search + 2 handoff cycles
`define BCH_DECODE_CYCLES 69

`endif
